// File: source/dekatronPkg.sv
package dekatronPkg;

    localparam int TubeCount = 3;                // Tubes in the chain, one per decimal digit
    localparam int MainCount = 10;               // Main cathodes per tube
    localparam int CathodeCount = 3 * MainCount; // Each main cathode is followed by two guides

    // Main cathodes sit at every third index
    // The right guide follows a main cathode and the left guide follows the right one
    typedef logic [CathodeCount-1:0] cathodeT;

    typedef logic [MainCount-1:0] glowT; // One-hot over the ten main cathodes

    typedef logic [3:0] digitT; // One BCD digit

    // Three BCD digits with the ones digit in the low bits
    typedef struct packed {
        digitT hundreds;
        digitT tens;
        digitT ones;
    } countT;

    typedef enum logic [1:0] {
        opUp,   // Count up by one
        opDown, // Count down by one
        opLoad  // Load loadValue into the chain
    } cmdOpE;

    typedef struct packed {
        cmdOpE op;
        countT loadValue; // Only meaningful for opLoad
    } cmdT;

    typedef enum logic [2:0] {
        phIdle,
        phFirst,  // First guide pulse
        phSecond, // Second guide pulse
        phSettle, // Glow falls onto the next main cathode
        phRipple  // Carry or borrow to the next tube
    } pulsePhaseE;

endpackage

// File: source/Dekatron.sv
`timescale 1ns/100ps

module Dekatron (
    input  logic              hsClk,
    input  logic              Rst_n,
    input  logic              PulseRight,
    input  logic              PulseLeft,
    input  dekatronPkg::glowT In,
    output dekatronPkg::glowT Out
);

    dekatronPkg::cathodeT cathodes; // Exactly one bit glows
    dekatronPkg::cathodeT inLong;   // Load value spread onto the main cathodes
    dekatronPkg::cathodeT fwd;
    dekatronPkg::cathodeT back;
    logic onMain;
    logic onRight;
    logic onLeft;

    // Glow position classes and the main cathode taps
    always_comb begin
        onMain = 1'b0;
        onRight = 1'b0;
        onLeft = 1'b0;
        inLong = '0;
        for (int k = 0; k < dekatronPkg::MainCount; k++) begin
            Out[k] = cathodes[3*k];
            inLong[3*k] = In[k];
            onMain = onMain | cathodes[3*k];
            onRight = onRight | cathodes[3*k+1];
            onLeft = onLeft | cathodes[3*k+2];
        end
    end

    // The ring closes between cathode 29 and cathode 0
    assign fwd = {cathodes[dekatronPkg::CathodeCount-2:0], cathodes[dekatronPkg::CathodeCount-1]};
    assign back = {cathodes[0], cathodes[dekatronPkg::CathodeCount-1:1]};

    always_ff @(posedge hsClk or negedge Rst_n) begin
        if (!Rst_n) begin
            cathodes <= dekatronPkg::cathodeT'(1); // Glow starts on main cathode 0
        end else if (|In) begin
            cathodes <= inLong; // Direct load wins over any guide pulse
        end else if (PulseRight) begin
            if (onMain) begin
                cathodes <= fwd; // Main jumps onto its right guide
            end else if (onLeft) begin
                cathodes <= back;
            end
        end else if (PulseLeft) begin
            if (onMain) begin
                cathodes <= back; // Main jumps onto the left guide below it
            end else if (onRight) begin
                cathodes <= fwd;
            end
        end else begin
            // With no pulse a guide hands the glow to its nearest main cathode
            if (onRight) begin
                cathodes <= back;
            end else if (onLeft) begin
                cathodes <= fwd;
            end
        end
    end

endmodule

// File: source/guidePulser.sv
`timescale 1ns/100ps

module guidePulser (
    input  logic               hsClk,
    input  logic               Rst_n,
    input  logic               stepReq,
    input  logic               stepDown,
    input  dekatronPkg::glowT  glow,
    output logic               PulseRight,
    output logic               PulseLeft,
    output logic               carry,
    output logic               busy,
    output dekatronPkg::digitT digit
);

    localparam dekatronPkg::digitT TopDigit = dekatronPkg::digitT'(dekatronPkg::MainCount - 1);

    dekatronPkg::pulsePhaseE phase;
    logic down;                      // Direction of the step in progress
    logic wrap;                      // Step leaves this digit and ripples on
    dekatronPkg::digitT glowDigit;   // Decoded main cathode
    dekatronPkg::digitT heldDigit;   // Last digit seen on a main cathode

    always_comb begin
        glowDigit = '0;
        for (int k = 0; k < dekatronPkg::MainCount; k++) begin
            if (glow[k]) begin
                glowDigit = dekatronPkg::digitT'(k);
            end
        end
    end

    // While the glow rests on a guide the display keeps the old digit
    assign digit = (|glow) ? glowDigit : heldDigit;

    always_ff @(posedge hsClk or negedge Rst_n) begin
        if (!Rst_n) begin
            phase <= dekatronPkg::phIdle;
            down <= 1'b0;
            wrap <= 1'b0;
            heldDigit <= '0;                // Tube comes out of reset on cathode 0
        end else begin
            if (|glow) begin
                heldDigit <= glowDigit;
            end
            case (phase)
                dekatronPkg::phIdle: begin
                    if (stepReq) begin
                        down <= stepDown;
                        wrap <= stepDown ? (digit == '0) : (digit == TopDigit);
                        phase <= dekatronPkg::phFirst;
                    end
                end
                dekatronPkg::phFirst: begin
                    phase <= dekatronPkg::phSecond;
                end
                dekatronPkg::phSecond: begin
                    phase <= dekatronPkg::phSettle;
                end
                dekatronPkg::phSettle: begin
                    phase <= wrap ? dekatronPkg::phRipple : dekatronPkg::phIdle;
                end
                default: begin
                    phase <= dekatronPkg::phIdle; // phRipple lasts one cycle
                end
            endcase
        end
    end

    // Up is right then left, down is left then right
    assign PulseRight = ((phase == dekatronPkg::phFirst) && !down)
                     || ((phase == dekatronPkg::phSecond) && down);
    assign PulseLeft = ((phase == dekatronPkg::phFirst) && down)
                    || ((phase == dekatronPkg::phSecond) && !down);

    assign carry = (phase == dekatronPkg::phRipple);
    assign busy = (phase != dekatronPkg::phIdle); // Still high in phRipple so chainBusy has no gap

endmodule

// File: source/countController.sv
`timescale 1ns/100ps

module countController #(
    parameter int QueueDepth = 4
) (
    input  logic                                               hsClk,
    input  logic                                               Rst_n,
    input  logic                                               cmdValid,
    input  dekatronPkg::cmdT                                   cmd,
    input  logic                                               chainBusy,
    output logic                                               stepReq,
    output logic                                               stepDown,
    output dekatronPkg::glowT [dekatronPkg::TubeCount-1:0]     loadGlow,
    output logic                                               creditReturn
);

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int FillW = $clog2(QueueDepth + 1);

    typedef logic [PtrW-1:0] ptrT;
    typedef logic [FillW-1:0] fillT;

    typedef enum logic [2:0] {
        ctlIdle,
        ctlStep, // One-cycle step to tube 0
        ctlWait, // Chain is pulsing and rippling
        ctlLoad, // Load pattern on the tube inputs
        ctlDone  // Credit goes back to the host
    } ctlStateE;

    dekatronPkg::cmdT queue [QueueDepth];
    ptrT wrPtr;
    ptrT rdPtr;
    fillT fill;
    ctlStateE state;
    dekatronPkg::cmdT cur;                                   // Command being executed
    dekatronPkg::digitT [dekatronPkg::TubeCount-1:0] loadDigits;
    logic pop;

    function automatic ptrT nextPtr(ptrT p);
        return (p == ptrT'(QueueDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (state == ctlIdle) && (fill != '0);

    // The host only writes while it holds a credit so the queue never overflows
    always_ff @(posedge hsClk) begin
        if (cmdValid) begin
            queue[wrPtr] <= cmd;
        end
    end

    always_ff @(posedge hsClk or negedge Rst_n) begin
        if (!Rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
        end else begin
            if (cmdValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({cmdValid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge hsClk or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= ctlIdle;
            cur <= '0;
        end else begin
            case (state)
                ctlIdle: begin
                    if (pop) begin
                        cur <= queue[rdPtr];
                        state <= (queue[rdPtr].op == dekatronPkg::opLoad) ? ctlLoad : ctlStep;
                    end
                end
                ctlStep: state <= ctlWait;
                ctlWait: begin
                    if (!chainBusy) begin
                        state <= ctlDone; // Last ripple has settled
                    end
                end
                ctlLoad: state <= ctlDone;
                default: state <= ctlIdle;
            endcase
        end
    end

    assign loadDigits = cur.loadValue;

    // Each BCD digit becomes a one-hot main cathode for exactly one cycle
    always_comb begin
        for (int k = 0; k < dekatronPkg::TubeCount; k++) begin
            loadGlow[k] = (state == ctlLoad) ? (dekatronPkg::glowT'(1) << loadDigits[k]) : '0;
        end
    end

    assign stepReq = (state == ctlStep);
    assign stepDown = (cur.op == dekatronPkg::opDown); // Held for the whole ripple
    assign creditReturn = (state == ctlDone);

endmodule

// File: source/dekatronCounter.sv
`timescale 1ns/100ps

module dekatronCounter #(
    parameter int QueueDepth = 4
) (
    input  logic               hsClk,
    input  logic               Rst_n,
    input  logic               cmdValid,
    input  dekatronPkg::cmdT   cmd,
    output logic               creditReturn,
    output dekatronPkg::countT count
);

    logic stepDown;
    logic chainBusy;
    logic [dekatronPkg::TubeCount-1:0] stepChain;  // Entry k is the step into tube k
    logic [dekatronPkg::TubeCount-1:0] busyVec;
    dekatronPkg::glowT [dekatronPkg::TubeCount-1:0] loadGlow;
    dekatronPkg::glowT [dekatronPkg::TubeCount-1:0] tubeGlow;
    dekatronPkg::digitT [dekatronPkg::TubeCount-1:0] digits;

    countController #(
        .QueueDepth(QueueDepth)
    ) uController (
        .hsClk       (hsClk),
        .Rst_n       (Rst_n),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .chainBusy   (chainBusy),
        .stepReq     (stepChain[0]),
        .stepDown    (stepDown),
        .loadGlow    (loadGlow),
        .creditReturn(creditReturn)
    );

    for (genvar k = 0; k < dekatronPkg::TubeCount; k++) begin : gTube
        logic pulseRight;
        logic pulseLeft;

        if (k < dekatronPkg::TubeCount - 1) begin : gMid
            guidePulser uPulser (
                .hsClk(hsClk), .Rst_n(Rst_n),
                .stepReq(stepChain[k]), .stepDown(stepDown), .glow(tubeGlow[k]),
                .PulseRight(pulseRight), .PulseLeft(pulseLeft),
                .carry(stepChain[k+1]), .busy(busyVec[k]), .digit(digits[k])
            );
        end else begin : gLast
            // Top digit carry is dropped so the count wraps modulo 1000
            guidePulser uPulser (
                .hsClk(hsClk), .Rst_n(Rst_n),
                .stepReq(stepChain[k]), .stepDown(stepDown), .glow(tubeGlow[k]),
                .PulseRight(pulseRight), .PulseLeft(pulseLeft),
                .carry(), .busy(busyVec[k]), .digit(digits[k])
            );
        end

        Dekatron uTube (
            .hsClk(hsClk), .Rst_n(Rst_n),
            .PulseRight(pulseRight), .PulseLeft(pulseLeft),
            .In(loadGlow[k]), .Out(tubeGlow[k])
        );
    end

    assign chainBusy = |busyVec;
    assign count = digits; // Tube 0 lands on the ones digit

endmodule

// File: include/cmdTable.svh
`ifndef CMD_TABLE_SVH
`define CMD_TABLE_SVH

// Columns: command op, load value in BCD, expected count in BCD once the credit is back
// Rows run in order starting from the reset count of 000

typedef struct packed {
    dekatronPkg::cmdOpE op;
    dekatronPkg::countT loadValue; // Ignored for up and down
    dekatronPkg::countT expCount;
} tableRowT;

localparam int TableLen = 25;

localparam tableRowT cmdTable [TableLen] = '{
    '{dekatronPkg::opUp,   12'h000, 12'h001},
    '{dekatronPkg::opUp,   12'h000, 12'h002},
    '{dekatronPkg::opLoad, 12'h008, 12'h008},
    '{dekatronPkg::opUp,   12'h000, 12'h009},
    '{dekatronPkg::opUp,   12'h000, 12'h010}, // Carry into the tens tube
    '{dekatronPkg::opDown, 12'h000, 12'h009}, // Borrow back out of it
    '{dekatronPkg::opLoad, 12'h099, 12'h099},
    '{dekatronPkg::opUp,   12'h000, 12'h100}, // Carry ripples through two tubes
    '{dekatronPkg::opDown, 12'h000, 12'h099},
    '{dekatronPkg::opLoad, 12'h000, 12'h000},
    '{dekatronPkg::opDown, 12'h000, 12'h999}, // Borrow through all three tubes
    '{dekatronPkg::opUp,   12'h000, 12'h000}, // Wraps modulo 1000
    '{dekatronPkg::opLoad, 12'h100, 12'h100},
    '{dekatronPkg::opDown, 12'h000, 12'h099},
    '{dekatronPkg::opLoad, 12'h998, 12'h998},
    '{dekatronPkg::opUp,   12'h000, 12'h999},
    '{dekatronPkg::opUp,   12'h000, 12'h000},
    '{dekatronPkg::opDown, 12'h000, 12'h999},
    '{dekatronPkg::opLoad, 12'h509, 12'h509},
    '{dekatronPkg::opUp,   12'h000, 12'h510},
    '{dekatronPkg::opDown, 12'h000, 12'h509},
    '{dekatronPkg::opLoad, 12'h890, 12'h890},
    '{dekatronPkg::opDown, 12'h000, 12'h889},
    '{dekatronPkg::opUp,   12'h000, 12'h890},
    '{dekatronPkg::opUp,   12'h000, 12'h891}
};

`endif

// File: test/dekatronCounterTb.sv
`timescale 1ns/100ps

module dekatronCounterTb;

    localparam int QueueDepth = 4;
    localparam int Timeout = 400;    // Cycles allowed for any single wait
    localparam int Seed = 95182;
    localparam int RandomCmds = 40;

    `include "cmdTable.svh"

    logic hsClk;
    logic Rst_n;
    logic cmdValid;
    dekatronPkg::cmdT cmd;
    logic creditReturn;
    dekatronPkg::countT count;

    int credits;  // Credits the host holds
    int model;    // Reference count, 0 to 999

    dekatronCounter #(
        .QueueDepth(QueueDepth)
    ) DUT (
        .hsClk       (hsClk),
        .Rst_n       (Rst_n),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .creditReturn(creditReturn),
        .count       (count)
    );

    always #4 hsClk = ~hsClk;

    task automatic abortRun();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Advance to the next falling edge and collect a returned credit
    task automatic tick();
        @(negedge hsClk);
        if (creditReturn) begin
            credits++;
            if (credits > QueueDepth) begin
                $display("creditReturn pulsed while no command was outstanding");
                abortRun();
            end
        end
    endtask

    function automatic dekatronPkg::countT toCount(input int v);
        dekatronPkg::countT c;
        c.ones = dekatronPkg::digitT'(v % 10);
        c.tens = dekatronPkg::digitT'((v / 10) % 10);
        c.hundreds = dekatronPkg::digitT'((v / 100) % 10);
        return c;
    endfunction

    function automatic int nextModel(input int m, input dekatronPkg::cmdT c);
        case (c.op)
            dekatronPkg::opUp:   return (m + 1) % 1000;
            dekatronPkg::opDown: return (m + 999) % 1000; // Down from 000 gives 999
            default: return int'(c.loadValue.hundreds) * 100 + int'(c.loadValue.tens) * 10
                          + int'(c.loadValue.ones);
        endcase
    endfunction

    task automatic checkCount(input string name, input dekatronPkg::countT exp,
                              input dekatronPkg::countT act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkCredits(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
            abortRun();
        end
    endtask

    // Spend a credit on one command, waiting for one if none is held
    task automatic sendCmd(input string name, input dekatronPkg::cmdT c);
        int waited;
        waited = 0;
        while (credits == 0) begin
            if (waited >= Timeout) begin
                $display("%s: no credit came back within %0d cycles", name, Timeout);
                abortRun();
            end
            tick();
            waited++;
        end
        cmdValid = 1'b1;
        cmd = c;
        credits--;
        model = nextModel(model, c);
        tick();
        cmdValid = 1'b0;
    endtask

    task automatic drainCredits(input string name);
        int waited;
        waited = 0;
        while (credits != QueueDepth) begin
            if (waited >= Timeout) begin
                $display("%s: no credit came back within %0d cycles", name, Timeout);
                abortRun();
            end
            tick();
            waited++;
        end
    endtask

    initial begin
        dekatronPkg::cmdT c;
        string name;
        int v;
        hsClk = 1'b0;
        Rst_n = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        credits = QueueDepth;
        model = 0;
        void'($urandom(Seed));
        repeat (16) @(negedge hsClk);
        Rst_n = 1'b1;
        tick();
        checkCount("after reset", 12'h000, count);

        for (int i = 0; i < TableLen; i++) begin
            name = $sformatf("table row %0d", i);
            c.op = cmdTable[i].op;
            c.loadValue = cmdTable[i].loadValue;
            sendCmd(name, c);
            drainCredits(name);
            checkCount(name, cmdTable[i].expCount, count);
            checkCount({name, " model"}, toCount(model), count);
        end

        // Burst of QueueDepth commands on back-to-back cycles
        c.loadValue = '0;
        c.op = dekatronPkg::opUp;
        sendCmd("burst up", c);
        c.op = dekatronPkg::opLoad;
        c.loadValue = 12'h399;
        sendCmd("burst load", c);
        c.op = dekatronPkg::opUp;
        sendCmd("burst second up", c);
        c.op = dekatronPkg::opDown;
        sendCmd("burst down", c);
        checkCredits("burst credits in flight", 0, credits);
        drainCredits("burst");
        checkCount("burst result", toCount(model), count);
        repeat (20) tick();  // No stray credit may follow the burst

        for (int i = 0; i < RandomCmds; i++) begin
            v = $urandom % 3;
            c.op = (v == 0) ? dekatronPkg::opUp
                 : (v == 1) ? dekatronPkg::opDown : dekatronPkg::opLoad;
            c.loadValue = toCount($urandom % 1000);
            sendCmd($sformatf("random cmd %0d", i), c);
        end
        drainCredits("random mix");
        checkCount("random mix result", toCount(model), count);

        $display("all tests passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/dekatronPkg.sv
source/Dekatron.sv
source/guidePulser.sv
source/countController.sv
source/dekatronCounter.sv
test/dekatronCounterTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, failing on any error

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=dekatronCounterTb

verilator --binary --timing -Wno-fatal --top-module "$TOP" -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0
